/* sb_macros.svh */
`ifndef SB_MACROS_SVH
`define SB_MACROS_SVH

`default_nettype none

`define SB_NUM_ENTRIES 8  // Store buffer depth and producer credit pool
`define SB_ADDR_W      64
`define SB_DATA_W      64
`define SB_MEM_CREDITS 4  // Memory write port credits after reset

`default_nettype wire

`endif

/* sb_pkg.sv */
`default_nettype none

package sb_pkg;

    // Raw memory size code as carried by a store or a load
    typedef logic [3:0] size_code_t;

    // Field view of the same code
    typedef struct packed {
        logic       block;  // Set for 16/32/64 byte fill stores
        logic       uns;    // Load sign flag, stores ignore it
        logic [1:0] lg;     // log2 of size inside its class
    } size_fields_t;

    // Exact code compare on one side, field decode on the other
    typedef union packed {
        size_code_t   raw;
        size_fields_t fields;
    } mem_size_u;

    // log2 of a byte granule, 0 (byte) up to 6 (64 byte block)
    typedef logic [2:0] granule_t;

endpackage

`default_nettype wire

/* st_ingress.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"
`default_nettype none

module st_ingress (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    input  wire logic                  st_valid_i,
    input  wire logic [`SB_ADDR_W-1:0] st_addr_i,
    input  wire logic [`SB_DATA_W-1:0] st_data_i,
    input  wire sb_pkg::mem_size_u     st_size_i,

    input  wire logic                  pop_i,       // Drain retired the head entry

    output logic                       wr_valid_o,
    output logic [`SB_ADDR_W-1:0]      wr_addr_o,
    output logic [`SB_DATA_W-1:0]      wr_data_o,
    output sb_pkg::mem_size_u          wr_size_o,

    output logic                       st_credit_o  // One pulse per freed entry
);

    localparam int OUT_W = $clog2(`SB_NUM_ENTRIES) + 1;

    // Credits spent by the producer and not yet given back
    logic [OUT_W-1:0] outstanding_q;

    // Control path
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            wr_valid_o    <= 1'b0;
            st_credit_o   <= 1'b0;
            outstanding_q <= '0;
        end else begin
            wr_valid_o    <= st_valid_i;
            st_credit_o   <= pop_i;  // Credit goes back the cycle after pop
            outstanding_q <= outstanding_q
                             + {{(OUT_W-1){1'b0}}, st_valid_i}
                             - {{(OUT_W-1){1'b0}}, st_credit_o};
        end
    end

    // Payload stage, only loaded on an accepted store
    always_ff @(posedge clk_i) begin
        if (st_valid_i) begin
            wr_addr_o <= st_addr_i;
            wr_data_o <= st_data_i;
            wr_size_o <= st_size_i;
        end
    end

endmodule

`default_nettype wire

/* store_buffer.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"
`default_nettype none

module store_buffer (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    input  wire logic                  wr_valid_i,
    input  wire logic [`SB_ADDR_W-1:0] wr_addr_i,
    input  wire logic [`SB_DATA_W-1:0] wr_data_i,
    input  wire sb_pkg::mem_size_u     wr_size_i,

    input  wire logic                  pop_i,

    input  wire logic [`SB_ADDR_W-1:0] load_addr_i,
    input  wire sb_pkg::mem_size_u     load_size_i,

    output logic                       head_valid_o,
    output logic [`SB_ADDR_W-1:0]      head_addr_o,
    output logic [`SB_DATA_W-1:0]      head_data_o,
    output sb_pkg::mem_size_u          head_size_o,

    output logic                       empty_o,
    output logic                       collision_o  // Load may overlap a buffered store
);

    localparam int DEPTH = `SB_NUM_ENTRIES;
    localparam int PTR_W = $clog2(DEPTH);

    logic [PTR_W-1:0] head_q;
    logic [PTR_W-1:0] tail_q;
    logic [PTR_W:0]   count_q;   // One bit wider than the pointers
    logic [DEPTH-1:0] valid_q;

    logic [`SB_ADDR_W-1:0] addr_mem [DEPTH];
    logic [`SB_DATA_W-1:0] data_mem [DEPTH];
    sb_pkg::mem_size_u     size_mem [DEPTH];

    logic pop_en;

    // Exact block codes give 16/32/64 byte granules, everything else is scalar
    function automatic sb_pkg::granule_t size_granule(input sb_pkg::mem_size_u sz);
        case (sz.raw)
            4'b1000, 4'b1001, 4'b1010: size_granule = 3'd4 + {1'b0, sz.fields.lg};
            default:                   size_granule = {1'b0, sz.fields.lg};
        endcase
    endfunction

    assign empty_o = (count_q == '0);
    assign pop_en  = pop_i & ~empty_o;  // Guard against a stray pop

    // Pointers and occupancy
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            head_q  <= '0;
            tail_q  <= '0;
            count_q <= '0;
            valid_q <= '0;
        end else begin
            if (wr_valid_i) begin
                tail_q          <= tail_q + 1'b1;
                valid_q[tail_q] <= 1'b1;
            end
            if (pop_en) begin
                head_q          <= head_q + 1'b1;
                valid_q[head_q] <= 1'b0;
            end
            count_q <= count_q + {{PTR_W{1'b0}}, wr_valid_i} - {{PTR_W{1'b0}}, pop_en};
        end
    end

    // Entry storage
    always_ff @(posedge clk_i) begin
        if (wr_valid_i) begin
            addr_mem[tail_q] <= wr_addr_i;
            data_mem[tail_q] <= wr_data_i;
            size_mem[tail_q] <= wr_size_i;
        end
    end

    // Oldest store, zeroed while empty
    assign head_valid_o = ~empty_o;
    assign head_addr_o  = empty_o ? '0 : addr_mem[head_q];
    assign head_data_o  = empty_o ? '0 : data_mem[head_q];
    assign head_size_o  = empty_o ? '0 : size_mem[head_q];

    // Page offset compare down to the coarser granule of the pair
    always_comb begin : collision_detector
        sb_pkg::granule_t g_load;
        sb_pkg::granule_t g_entry;
        sb_pkg::granule_t g_max;
        logic [11:0]      mask;
        collision_o = 1'b0;
        g_load      = size_granule(load_size_i);
        for (int j = 0; j < DEPTH; j++) begin
            g_entry = size_granule(size_mem[j]);
            g_max   = (g_entry > g_load) ? g_entry : g_load;
            mask    = 12'hfff << g_max;
            if (valid_q[j] && (((addr_mem[j][11:0] ^ load_addr_i[11:0]) & mask) == '0)) begin
                collision_o = 1'b1;
            end
        end
    end

endmodule

`default_nettype wire

/* st_drain.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"
`default_nettype none

module st_drain (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    input  wire logic                  head_valid_i,
    input  wire logic [`SB_ADDR_W-1:0] head_addr_i,
    input  wire logic [`SB_DATA_W-1:0] head_data_i,
    input  wire sb_pkg::mem_size_u     head_size_i,

    output logic                       pop_o,  // With the last beat of the head entry

    output logic                       mem_valid_o,
    output logic [`SB_ADDR_W-1:0]      mem_addr_o,
    output logic [`SB_DATA_W-1:0]      mem_data_o,
    output logic [7:0]                 mem_strb_o,
    input  wire logic                  mem_credit_i
);

    localparam int CRED_W = $clog2(`SB_MEM_CREDITS + 1);

    logic [2:0]        beat_q;        // Beat index inside the head entry
    logic [CRED_W-1:0] mem_credit_q;  // Memory credits on hand

    sb_pkg::granule_t g;
    logic [3:0]       last_idx;
    logic             last_beat;
    logic [7:0]       byte_mask;

    // Granule from the field view, blocks sit 4 above their lg
    assign g = head_size_i.fields.block ? 3'd4 + {1'b0, head_size_i.fields.lg}
                                        : {1'b0, head_size_i.fields.lg};

    // 16/32/64 byte blocks take 2/4/8 doubleword beats
    assign last_idx  = (g > 3'd3) ? (4'd1 << (g - 3'd3)) - 4'd1 : 4'd0;
    assign last_beat = ({1'b0, beat_q} == last_idx);

    always_comb begin
        case (g)
            3'd0:    byte_mask = 8'h01;
            3'd1:    byte_mask = 8'h03;
            3'd2:    byte_mask = 8'h0f;
            default: byte_mask = 8'hff;
        endcase
    end

    // A beat goes out whenever there is a head entry and a credit
    assign mem_valid_o = head_valid_i && (mem_credit_q != '0);
    assign pop_o       = mem_valid_o && last_beat;

    // Doubleword address, stepped by beat for blocks
    assign mem_addr_o = {head_addr_i[`SB_ADDR_W-1:3] + {{(`SB_ADDR_W-6){1'b0}}, beat_q}, 3'b000};

    // Blocks are aligned so the lane shift is zero and the doubleword repeats
    assign mem_data_o = head_data_i << {head_addr_i[2:0], 3'b000};
    assign mem_strb_o = head_size_i.fields.block ? 8'hff : byte_mask << head_addr_i[2:0];

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            beat_q       <= '0;
            mem_credit_q <= CRED_W'(`SB_MEM_CREDITS);
        end else begin
            if (mem_valid_o) begin
                beat_q <= last_beat ? 3'd0 : beat_q + 3'd1;
            end
            mem_credit_q <= mem_credit_q
                            + {{(CRED_W-1){1'b0}}, mem_credit_i}
                            - {{(CRED_W-1){1'b0}}, mem_valid_o};
        end
    end

endmodule

`default_nettype wire

/* lsu_store_top.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"
`default_nettype none

module lsu_store_top (
    input  wire logic                  clk_i,
    input  wire logic                  rstn_i,

    // Producer side
    input  wire logic                  st_valid_i,
    input  wire logic [`SB_ADDR_W-1:0] st_addr_i,
    input  wire logic [`SB_DATA_W-1:0] st_data_i,
    input  wire sb_pkg::mem_size_u     st_size_i,
    output logic                       st_credit_o,

    // Load probe
    input  wire logic [`SB_ADDR_W-1:0] load_addr_i,
    input  wire sb_pkg::mem_size_u     load_size_i,
    output logic                       collision_o,

    // Memory write port
    output logic                       mem_valid_o,
    output logic [`SB_ADDR_W-1:0]      mem_addr_o,
    output logic [`SB_DATA_W-1:0]      mem_data_o,
    output logic [7:0]                 mem_strb_o,
    input  wire logic                  mem_credit_i,

    output logic                       empty_o
);

    logic                  wr_valid;
    logic [`SB_ADDR_W-1:0] wr_addr;
    logic [`SB_DATA_W-1:0] wr_data;
    sb_pkg::mem_size_u     wr_size;

    logic                  head_valid;
    logic [`SB_ADDR_W-1:0] head_addr;
    logic [`SB_DATA_W-1:0] head_data;
    sb_pkg::mem_size_u     head_size;

    logic                  pop;  // Shared by buffer and ingress

    st_ingress u_ingress (
        .clk_i, .rstn_i,
        .st_valid_i, .st_addr_i, .st_data_i, .st_size_i,
        .pop_i      (pop),
        .wr_valid_o (wr_valid),
        .wr_addr_o  (wr_addr),
        .wr_data_o  (wr_data),
        .wr_size_o  (wr_size),
        .st_credit_o
    );

    store_buffer u_buffer (
        .clk_i, .rstn_i,
        .wr_valid_i   (wr_valid),
        .wr_addr_i    (wr_addr),
        .wr_data_i    (wr_data),
        .wr_size_i    (wr_size),
        .pop_i        (pop),
        .load_addr_i, .load_size_i,
        .head_valid_o (head_valid),
        .head_addr_o  (head_addr),
        .head_data_o  (head_data),
        .head_size_o  (head_size),
        .empty_o, .collision_o
    );

    st_drain u_drain (
        .clk_i, .rstn_i,
        .head_valid_i (head_valid),
        .head_addr_i  (head_addr),
        .head_data_i  (head_data),
        .head_size_i  (head_size),
        .pop_o        (pop),
        .mem_valid_o, .mem_addr_o, .mem_data_o, .mem_strb_o, .mem_credit_i
    );

endmodule

`default_nettype wire

/* lsu_store_properties.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"
`default_nettype none

module lsu_store_properties #(
    parameter int MAX = 1
) (
    input wire logic       clk_i,
    input wire logic       rstn_i,
    input wire logic [7:0] avail_i,  // Credits still on hand
    input wire logic       spend_i,  // One credit used this cycle
    input wire logic       give_i    // One credit returned this cycle
);

    // A negative pool wraps above MAX, so one range check covers both ends
    a_pool_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        avail_i <= 8'(MAX))
        else $error("credit pool out of range: %0d", avail_i);

    a_no_overspend: assert property (@(posedge clk_i) disable iff (!rstn_i)
        spend_i |-> avail_i != 8'd0)
        else $error("credit spent with an empty pool");

    a_no_overfill: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (give_i && !spend_i) |-> avail_i != 8'(MAX))
        else $error("credit returned to a full pool");

endmodule

// Producer credits seen from the ingress side
bind st_ingress lsu_store_properties #(.MAX(`SB_NUM_ENTRIES)) u_credit_props (
    .clk_i, .rstn_i,
    .avail_i (8'(`SB_NUM_ENTRIES - outstanding_q)),
    .spend_i (st_valid_i),
    .give_i  (st_credit_o)
);

// Memory port credits held by the drain
bind st_drain lsu_store_properties #(.MAX(`SB_MEM_CREDITS)) u_mem_props (
    .clk_i, .rstn_i,
    .avail_i (8'(mem_credit_q)),
    .spend_i (mem_valid_o),
    .give_i  (mem_credit_i)
);

`default_nettype wire

/* tb_lsu_store.sv */
`timescale 1ns/1ps
`include "sb_macros.svh"
`default_nettype none

module tb_lsu_store;

    localparam int NUM_STORES  = 200;
    localparam int CYCLE_LIMIT = NUM_STORES * 8 * 4 + 500;  // 8 beats worst case plus stalls

    logic                  clk_i;
    logic                  rstn_i;
    logic                  st_valid_i;
    logic [`SB_ADDR_W-1:0] st_addr_i;
    logic [`SB_DATA_W-1:0] st_data_i;
    sb_pkg::mem_size_u     st_size_i;
    logic                  st_credit_o;
    logic [`SB_ADDR_W-1:0] load_addr_i;
    sb_pkg::mem_size_u     load_size_i;
    logic                  collision_o;
    logic                  mem_valid_o;
    logic [`SB_ADDR_W-1:0] mem_addr_o;
    logic [`SB_DATA_W-1:0] mem_data_o;
    logic [7:0]            mem_strb_o;
    logic                  mem_credit_i;
    logic                  empty_o;

    // Reference model state
    logic [63:0] q_addr [$];     // Buffered stores, oldest first
    logic [63:0] q_data [$];
    logic [3:0]  q_size [$];
    logic        ing_valid;      // Store sitting in the ingress register
    logic [63:0] ing_addr;
    logic [63:0] ing_data;
    logic [3:0]  ing_size;
    logic [63:0] last_st_addr;
    logic        exp_valid;
    logic        exp_credit;
    int          due [$];        // Cycles at which memory credits may go back
    int          beat;
    int          mem_cred;
    int          prod_cred;
    int          cycle;
    int          sent;
    logic [31:0] rng_state;

    lsu_store_top u_dut (.*);

    always #20 clk_i = ~clk_i;

    function automatic logic [31:0] next_random();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    function automatic int granule_of(input logic [3:0] code);
        return code[3] ? 4 + int'(code[1:0]) : int'(code[1:0]);  // Blocks start at 16 bytes
    endfunction

    function automatic int beat_count(input logic [3:0] code);
        return code[3] ? (2 << code[1:0]) : 1;
    endfunction

    // Bits 11 down to the coarser granule must all agree for a hit
    function automatic logic expect_collision(input logic [63:0] la, input logic [3:0] ls);
        int   g;
        logic same;
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < q_addr.size(); i++) begin
            g    = (granule_of(q_size[i]) > granule_of(ls)) ? granule_of(q_size[i])
                                                          : granule_of(ls);
            same = 1'b1;
            for (int b = g; b < 12; b++) begin
                if (la[b] != q_addr[i][b]) same = 1'b0;
            end
            if (same) hit = 1'b1;
        end
        return hit;
    endfunction

    task automatic fail_now();
        $display(">>> FAIL");
        $fatal(1, "stopped at first error");
    endtask

    task automatic check_eq(input string name, input logic [63:0] got, input logic [63:0] exp);
        assert (got === exp) else begin
            $display("MISMATCH %s got 0x%h expected 0x%h (cycle %0d)", name, got, exp, cycle);
            fail_now();
        end
    endtask

    task automatic drive_inputs();
        logic [31:0] r;
        logic [1:0]  lg;
        logic [63:0] addr;
        int          idx;
        r          = next_random();
        st_valid_i = 1'b0;
        if (sent < NUM_STORES && prod_cred > 0 && r[1:0] != 2'd0) begin
            addr       = {next_random(), next_random()};
            addr[11:8] = 4'h0;  // One 256 byte window so loads hit often
            if (r[5:4] == 2'd0) begin
                lg            = (r[3:2] == 2'd3) ? 2'd2 : r[3:2];
                st_size_i.raw = {2'b10, lg};
                addr          = addr & ~((64'd16 << lg) - 64'd1);
            end else begin
                lg            = r[3:2];
                st_size_i.raw = {1'b0, r[7], lg};  // Sign flag is ignored by stores
                addr          = addr & ~((64'd1 << lg) - 64'd1);
            end
            st_addr_i    = addr;
            st_data_i    = {next_random(), next_random()};
            st_valid_i   = 1'b1;
            last_st_addr = addr;
        end
        // Load probe, often near the last store
        r           = next_random();
        load_addr_i = {next_random(), next_random()};
        load_addr_i[11:8] = 4'h0;
        if (r[5]) load_addr_i[11:3] = last_st_addr[11:3];
        if (r[3:2] == 2'd0) begin
            load_size_i.raw = {2'b10, (r[1:0] == 2'd3) ? 2'd2 : r[1:0]};
        end else begin
            load_size_i.raw = {1'b0, r[4], r[1:0]};
        end
        // Memory returns at most one credit per cycle
        mem_credit_i = 1'b0;
        idx          = -1;
        foreach (due[i]) begin
            if (idx < 0 && due[i] <= cycle) idx = i;
        end
        if (idx >= 0) begin
            due.delete(idx);
            mem_credit_i = 1'b1;
        end
    endtask

    task automatic check_outputs();
        logic [63:0] addr;
        logic [63:0] data;
        logic [3:0]  sz;
        int          off;
        int          strb;
        exp_valid = (q_addr.size() != 0) && (mem_cred > 0);
        check_eq("mem_valid_o", 64'(mem_valid_o), 64'(exp_valid));
        check_eq("empty_o", 64'(empty_o), 64'(q_addr.size() == 0));
        check_eq("st_credit_o", 64'(st_credit_o), 64'(exp_credit));
        check_eq("collision_o", 64'(collision_o),
                 64'(expect_collision(load_addr_i, load_size_i.raw)));
        if (exp_valid) begin
            addr = q_addr[0];
            data = q_data[0];
            sz   = q_size[0];
            if (sz[3]) begin
                check_eq("mem_addr_o", mem_addr_o, addr + 64'(8 * beat));
                check_eq("mem_data_o", mem_data_o, data);  // Same doubleword every beat
                check_eq("mem_strb_o", 64'(mem_strb_o), 64'hff);
            end else begin
                off  = int'(addr[2:0]);
                strb = ((1 << (1 << sz[1:0])) - 1) << off;
                check_eq("mem_addr_o", mem_addr_o, {addr[63:3], 3'b000});
                check_eq("mem_data_o", mem_data_o, data << (8 * off));
                check_eq("mem_strb_o", 64'(mem_strb_o), 64'(strb[7:0]));
            end
        end
    endtask

    // State after the coming rising edge
    task automatic advance_model();
        if (exp_credit) begin
            prod_cred++;
        end
        exp_credit = 1'b0;
        if (exp_valid) begin
            mem_cred--;
            due.push_back(cycle + 1 + int'(next_random() % 32'd4));
            if (beat == beat_count(q_size[0]) - 1) begin
                q_addr.delete(0);
                q_data.delete(0);
                q_size.delete(0);
                beat       = 0;
                exp_credit = 1'b1;  // Credit shows up after the pop edge
            end else begin
                beat++;
            end
        end
        if (mem_credit_i) mem_cred++;
        if (ing_valid) begin
            q_addr.push_back(ing_addr);
            q_data.push_back(ing_data);
            q_size.push_back(ing_size);
        end
        ing_valid = st_valid_i;
        ing_addr  = st_addr_i;
        ing_data  = st_data_i;
        ing_size  = st_size_i.raw;
        if (st_valid_i) begin
            prod_cred--;
            sent++;
        end
    endtask

    initial begin
        clk_i           = 1'b0;
        rstn_i          = 1'b0;
        st_valid_i      = 1'b0;
        st_addr_i       = '0;
        st_data_i       = '0;
        st_size_i.raw   = 4'h0;
        load_addr_i     = '0;
        load_size_i.raw = 4'h0;
        mem_credit_i    = 1'b0;
        rng_state       = 32'd29;
        ing_valid       = 1'b0;
        ing_addr        = '0;
        ing_data        = '0;
        ing_size        = 4'h0;
        last_st_addr    = '0;
        exp_valid       = 1'b0;
        exp_credit      = 1'b0;
        beat            = 0;
        mem_cred        = `SB_MEM_CREDITS;
        prod_cred       = `SB_NUM_ENTRIES;
        cycle           = 0;
        sent            = 0;

        repeat (5) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        #10;
        check_eq("mem_valid_o", 64'(mem_valid_o), 64'd0);
        check_eq("st_credit_o", 64'(st_credit_o), 64'd0);
        check_eq("collision_o", 64'(collision_o), 64'd0);
        check_eq("empty_o", 64'(empty_o), 64'd1);

        while (!(sent == NUM_STORES && !ing_valid && q_addr.size() == 0 &&
                 prod_cred == `SB_NUM_ENTRIES && due.size() == 0)) begin
            @(negedge clk_i);
            cycle++;
            if (cycle > CYCLE_LIMIT) begin
                $display("Timeout: stores did not drain within %0d cycles", CYCLE_LIMIT);
                fail_now();
            end
            drive_inputs();
            #10;
            check_outputs();
            advance_model();
        end

        @(negedge clk_i);
        st_valid_i   = 1'b0;
        mem_credit_i = 1'b0;
        #10;
        check_eq("empty_o", 64'(empty_o), 64'd1);
        check_eq("mem_valid_o", 64'(mem_valid_o), 64'd0);
        check_eq("st_credit_o", 64'(st_credit_o), 64'd0);  // No credit beyond the pool
        check_eq("collision_o", 64'(collision_o), 64'd0);
        $display(">>> PASS");
        $finish;
    end

endmodule

`default_nettype wire

/* sim.f */
+incdir+.
sb_pkg.sv
st_ingress.sv
store_buffer.sv
st_drain.sv
lsu_store_top.sv
lsu_store_properties.sv
tb_lsu_store.sv

/* Makefile */
# Verilator flow for the store path testbench

VERILATOR ?= verilator
TOP       ?= tb_lsu_store
FILELIST  ?= sim.f
OBJ_DIR   ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_MSG  ?= >>> PASS

SIM_BIN := $(OBJ_DIR)/V$(TOP)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

$(SIM_BIN): $(FILELIST) $(wildcard *.sv *.svh)
	$(VERILATOR) --binary $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

# The run passes only if the pass line shows up in the output
sim: $(SIM_BIN)
	@out="$$($(SIM_BIN) 2>&1)"; \
	echo "$$out"; \
	echo "$$out" | grep -qF -- '$(PASS_MSG)'

clean:
	rm -rf $(OBJ_DIR)
